/* usb_tx_pkg.sv */
package usb_tx_pkg;

  // Packet buffer depth in bytes
  localparam int max_pkt = 8;
  // Byte count field width, holds 0 through 8
  localparam int nbytes_w = 4;

  // Full-speed line states as {d+, d-}
  localparam logic [1:0] line_j   = 2'b10;
  localparam logic [1:0] line_k   = 2'b01;
  localparam logic [1:0] line_se0 = 2'b00;

  // PID coding group lives in pid[1:0]
  localparam logic [1:0] pid_grp_data      = 2'b11;
  localparam logic [1:0] pid_grp_handshake = 2'b10;

  // Seven zeros then a one, sent LSB first
  localparam logic [7:0] sync_byte = 8'h80;

  // Wishbone word addresses
  localparam logic [3:0] addr_ctrl     = 4'd0;
  localparam logic [3:0] addr_status   = 4'd1;
  // Buffer spans 8 through 15
  localparam logic [3:0] addr_buf_base = 4'd8;

  // Which packet field a bit slot belongs to
  typedef enum logic [2:0] {
    ph_sync = 3'd0,
    ph_pid  = 3'd1,
    ph_data = 3'd2,
    ph_crc  = 3'd3,
    ph_eop  = 3'd4
  } tx_phase_e;

  // One bit slot on the shared timeline
  typedef struct packed {
    logic      valid;
    // Packet bit, unused in the CRC phase
    logic      value;
    tx_phase_e phase;
  } tx_bit_t;

  // Control word, PID in the low nibble
  typedef struct packed {
    logic [nbytes_w-1:0] nbytes;
    logic [3:0]          pid;
  } ctrl_word_t;

  // Write data seen as a buffer byte or as a control word
  typedef union packed {
    logic [7:0] raw;
    ctrl_word_t ctrl;
  } wb_wdata_u;

endpackage

/* usb_tx_regs.sv */
`timescale 1ns/1ps

module usb_tx_regs (
  input  logic                                   i_clk_12MHz,
  input  logic                                   i_rst_n,
  input  logic                                   i_wb_cyc,
  input  logic                                   i_wb_stb,
  input  logic                                   i_wb_we,
  input  logic [3:0]                             i_wb_adr,
  input  logic [7:0]                             i_wb_dat,
  input  logic                                   i_done,
  input  logic [$clog2(usb_tx_pkg::max_pkt)-1:0] i_rd_idx,
  output logic [7:0]                             o_wb_dat,
  output logic                                   o_wb_ack,
  output logic                                   o_start,
  output usb_tx_pkg::ctrl_word_t                 o_ctrl,
  output logic [7:0]                             o_rd_byte
);

  // Packet payload storage
  logic [7:0] buf_mem [usb_tx_pkg::max_pkt];

  usb_tx_pkg::wb_wdata_u wdata;
  usb_tx_pkg::ctrl_word_t ctrl_q;
  logic [$clog2(usb_tx_pkg::max_pkt)-1:0] buf_idx;
  logic [7:0] rdata_q;
  logic req;
  logic is_ctrl;
  logic is_status;
  logic is_buf;
  logic hold;
  logic accept;
  logic ack_q;
  logic ctrl_ack_q;
  logic start_q;
  logic busy_q;

  // Same write word, decoded per address below
  assign wdata = i_wb_dat;

  assign req       = i_wb_cyc && i_wb_stb;
  assign is_ctrl   = i_wb_adr == usb_tx_pkg::addr_ctrl;
  assign is_status = i_wb_adr == usb_tx_pkg::addr_status;
  assign is_buf    = i_wb_adr >= usb_tx_pkg::addr_buf_base;
  assign buf_idx   = i_wb_adr[$clog2(usb_tx_pkg::max_pkt)-1:0];

  // Control write waits while a packet is on the line
  // Done frees it in the same cycle so the ack follows right after EOP
  assign hold   = i_wb_we && is_ctrl && busy_q && !i_done;
  // No accept while ack is high, keeps ack one cycle wide
  assign accept = req && !ack_q && !hold;

  always_ff @(posedge i_clk_12MHz) begin
    if (!i_rst_n) begin
      ack_q      <= 1'b0;
      ctrl_ack_q <= 1'b0;
      start_q    <= 1'b0;
      busy_q     <= 1'b0;
      ctrl_q     <= '0;
    end else begin
      ack_q      <= accept;
      ctrl_ack_q <= accept && i_wb_we && is_ctrl;
      // Start follows the accepting ack by one cycle
      start_q    <= ctrl_ack_q;
      if (accept && i_wb_we && is_ctrl) begin
        ctrl_q <= wdata.ctrl;
        busy_q <= 1'b1;
      end else if (i_done) begin
        busy_q <= 1'b0;
      end
    end
  end

  // Buffer byte write
  always_ff @(posedge i_clk_12MHz) begin
    if (accept && i_wb_we && is_buf) begin
      buf_mem[buf_idx] <= wdata.raw;
    end
  end

  // Read data captured at accept, valid together with ack
  always_ff @(posedge i_clk_12MHz) begin
    if (accept) begin
      if (is_buf) begin
        rdata_q <= buf_mem[buf_idx];
      end else if (is_status) begin
        rdata_q <= {7'd0, busy_q};
      end else if (is_ctrl) begin
        rdata_q <= ctrl_q;
      end else begin
        rdata_q <= 8'd0;
      end
    end
  end

  // Sequencer side read port, combinational
  assign o_rd_byte = buf_mem[i_rd_idx];

  assign o_wb_dat = rdata_q;
  assign o_wb_ack = ack_q;
  assign o_start  = start_q;
  assign o_ctrl   = ctrl_q;

endmodule

/* usb_tx_sequencer.sv */
`timescale 1ns/1ps

module usb_tx_sequencer (
  input  logic                                   i_clk_12MHz,
  input  logic                                   i_rst_n,
  input  logic                                   i_start,
  input  usb_tx_pkg::ctrl_word_t                 i_ctrl,
  input  logic                                   i_stall,
  input  logic [7:0]                             i_rd_byte,
  output logic [$clog2(usb_tx_pkg::max_pkt)-1:0] o_rd_idx,
  output usb_tx_pkg::tx_bit_t                    o_bit
);

  logic                                active_q;
  usb_tx_pkg::tx_phase_e               phase_q;
  logic [2:0]                          bit_cnt_q;
  logic [usb_tx_pkg::nbytes_w-1:0]     byte_cnt_q;
  logic [7:0]                          shift_q;

  // Current slot, start overrides the idle state
  logic                                cur_valid;
  usb_tx_pkg::tx_phase_e               cur_phase;
  logic [2:0]                          cur_cnt;
  logic [usb_tx_pkg::nbytes_w-1:0]     cur_bytes;
  logic [7:0]                          cur_shift;
  logic [usb_tx_pkg::nbytes_w-1:0]     next_bytes;
  logic                                byte_end;
  logic                                is_data_pid;
  logic                                advance;

  always_comb begin
    cur_valid = active_q || i_start;
    cur_phase = i_start ? usb_tx_pkg::ph_sync : phase_q;
    cur_cnt   = i_start ? 3'd0 : bit_cnt_q;
    cur_bytes = i_start ? '0 : byte_cnt_q;
    cur_shift = i_start ? usb_tx_pkg::sync_byte : shift_q;
  end

  assign next_bytes  = cur_bytes + 1'b1;
  assign byte_end    = cur_cnt == 3'd7;
  assign is_data_pid = i_ctrl.pid[1:0] == usb_tx_pkg::pid_grp_data;
  // Stuffed zero on the line, everything holds
  assign advance     = cur_valid && !i_stall;

  // Index of the byte loaded at the end of this one
  assign o_rd_idx = (cur_phase == usb_tx_pkg::ph_data) ?
                    next_bytes[$clog2(usb_tx_pkg::max_pkt)-1:0] : '0;

  always_comb begin
    o_bit.valid = cur_valid;
    o_bit.value = cur_shift[0];
    o_bit.phase = cur_phase;
  end

  // Field FSM and counters
  always_ff @(posedge i_clk_12MHz) begin
    if (!i_rst_n) begin
      active_q   <= 1'b0;
      phase_q    <= usb_tx_pkg::ph_sync;
      bit_cnt_q  <= 3'd0;
      byte_cnt_q <= '0;
    end else if (advance) begin
      active_q   <= 1'b1;
      phase_q    <= cur_phase;
      bit_cnt_q  <= cur_cnt + 3'd1;
      byte_cnt_q <= cur_bytes;
      if (cur_phase == usb_tx_pkg::ph_eop) begin
        // Three EOP slots, SE0 SE0 J, then idle
        if (cur_cnt == 3'd2) begin
          active_q  <= 1'b0;
          phase_q   <= usb_tx_pkg::ph_sync;
          bit_cnt_q <= 3'd0;
        end
      end else if (byte_end) begin
        case (cur_phase)
          usb_tx_pkg::ph_sync: phase_q <= usb_tx_pkg::ph_pid;
          usb_tx_pkg::ph_pid: begin
            if (!is_data_pid) begin
              // Handshake has no payload and no CRC
              phase_q <= usb_tx_pkg::ph_eop;
            end else if (i_ctrl.nbytes == '0) begin
              phase_q    <= usb_tx_pkg::ph_crc;
              byte_cnt_q <= '0;
            end else begin
              phase_q <= usb_tx_pkg::ph_data;
            end
          end
          usb_tx_pkg::ph_data: begin
            byte_cnt_q <= next_bytes;
            if (next_bytes == i_ctrl.nbytes) begin
              phase_q    <= usb_tx_pkg::ph_crc;
              byte_cnt_q <= '0;
            end
          end
          usb_tx_pkg::ph_crc: begin
            // Byte count reused for the two CRC bytes
            if (cur_bytes != '0) begin
              phase_q <= usb_tx_pkg::ph_eop;
            end else begin
              byte_cnt_q <= next_bytes;
            end
          end
          default: phase_q <= usb_tx_pkg::ph_eop;
        endcase
      end
    end
  end

  // Byte shifter, LSB is the bit in flight
  always_ff @(posedge i_clk_12MHz) begin
    if (advance) begin
      if (!byte_end) begin
        shift_q <= cur_shift >> 1;
      end else if (cur_phase == usb_tx_pkg::ph_sync) begin
        // Check nibble is the complement of the PID
        shift_q <= {~i_ctrl.pid, i_ctrl.pid};
      end else begin
        shift_q <= i_rd_byte;
      end
    end
  end

endmodule

/* usb_tx_crc16.sv */
`timescale 1ns/1ps

module usb_tx_crc16 (
  input  logic                i_clk_12MHz,
  input  logic                i_rst_n,
  input  usb_tx_pkg::tx_bit_t i_bit,
  input  logic                i_stall,
  output logic                o_crc_bit
);

  logic [15:0] crc_q;
  logic        fb;

  // Reflected form of x^16+x^15+x^2+1, LSB is the oldest term
  assign fb = i_bit.value ^ crc_q[0];

  always_ff @(posedge i_clk_12MHz) begin
    if (!i_rst_n) begin
      crc_q <= '1;
    end else if (i_bit.valid && !i_stall) begin
      case (i_bit.phase)
        // All ones seed so leading zeros count
        usb_tx_pkg::ph_sync: crc_q <= '1;
        usb_tx_pkg::ph_data: begin
          crc_q <= {fb, crc_q[15], crc_q[14] ^ fb, crc_q[13:2], crc_q[1] ^ fb};
        end
        // Remainder goes out LSB first
        usb_tx_pkg::ph_crc: crc_q <= crc_q >> 1;
        default: crc_q <= crc_q;
      endcase
    end
  end

  // Inverted so trailing zeros are still caught
  assign o_crc_bit = ~crc_q[0];

endmodule

/* usb_tx_line.sv */
`timescale 1ns/1ps

module usb_tx_line (
  input  logic                i_clk_12MHz,
  input  logic                i_rst_n,
  input  usb_tx_pkg::tx_bit_t i_bit,
  input  logic                i_crc_bit,
  output logic                o_stall,
  output logic                o_done,
  output logic                o_dp,
  output logic                o_dn,
  output logic                o_tx_en
);

  logic [2:0] ones_q;
  logic [1:0] eop_cnt_q;
  logic [1:0] pn_q;
  logic       done_q;
  logic       tx_en_q;
  logic       send_bit;
  logic       in_eop;

  // Six ones in a row, next line bit is a stuffed zero
  assign o_stall = ones_q == 3'd6;

  // CRC phase slots carry the remainder bit instead
  assign send_bit = (i_bit.phase == usb_tx_pkg::ph_crc) ? i_crc_bit : i_bit.value;
  assign in_eop   = i_bit.phase == usb_tx_pkg::ph_eop;

  always_ff @(posedge i_clk_12MHz) begin
    if (!i_rst_n) begin
      ones_q    <= 3'd0;
      eop_cnt_q <= 2'd0;
      pn_q      <= usb_tx_pkg::line_j;
      done_q    <= 1'b0;
      tx_en_q   <= 1'b0;
    end else begin
      done_q <= 1'b0;
      // Enable drops the cycle after the closing J
      if (done_q) begin
        tx_en_q <= 1'b0;
      end else if (i_bit.valid) begin
        tx_en_q <= 1'b1;
      end
      if (i_bit.valid) begin
        if (o_stall) begin
          // Stuffed zero toggles the line
          pn_q   <= ~pn_q;
          ones_q <= 3'd0;
        end else if (in_eop) begin
          ones_q <= 3'd0;
          if (eop_cnt_q == 2'd2) begin
            // Back to idle J, done marks this cycle
            pn_q      <= usb_tx_pkg::line_j;
            eop_cnt_q <= 2'd0;
            done_q    <= 1'b1;
          end else begin
            pn_q      <= usb_tx_pkg::line_se0;
            eop_cnt_q <= eop_cnt_q + 2'd1;
          end
        end else if (send_bit) begin
          // NRZI one holds the level
          ones_q <= ones_q + 3'd1;
        end else begin
          pn_q   <= ~pn_q;
          ones_q <= 3'd0;
        end
      end
    end
  end

  assign o_done  = done_q;
  assign o_tx_en = tx_en_q;
  assign o_dp    = pn_q[1];
  assign o_dn    = pn_q[0];

endmodule

/* usb_tx_top.sv */
`timescale 1ns/1ps

module usb_tx_top (
  input  logic       i_clk_12MHz,
  input  logic       i_rst_n,
  input  logic       i_wb_cyc,
  input  logic       i_wb_stb,
  input  logic       i_wb_we,
  input  logic [3:0] i_wb_adr,
  input  logic [7:0] i_wb_dat,
  output logic [7:0] o_wb_dat,
  output logic       o_wb_ack,
  output logic       o_dp,
  output logic       o_dn,
  output logic       o_tx_en
);

  usb_tx_pkg::ctrl_word_t                 ctrl;
  usb_tx_pkg::tx_bit_t                    tx_bit;
  logic [$clog2(usb_tx_pkg::max_pkt)-1:0] rd_idx;
  logic [7:0]                             rd_byte;
  logic                                   start;
  logic                                   stall;
  logic                                   done;
  logic                                   crc_bit;

  // Bus window, buffer and busy flag
  usb_tx_regs u_regs (
    .i_clk_12MHz (i_clk_12MHz),
    .i_rst_n     (i_rst_n),
    .i_wb_cyc    (i_wb_cyc),
    .i_wb_stb    (i_wb_stb),
    .i_wb_we     (i_wb_we),
    .i_wb_adr    (i_wb_adr),
    .i_wb_dat    (i_wb_dat),
    .i_done      (done),
    .i_rd_idx    (rd_idx),
    .o_wb_dat    (o_wb_dat),
    .o_wb_ack    (o_wb_ack),
    .o_start     (start),
    .o_ctrl      (ctrl),
    .o_rd_byte   (rd_byte)
  );

  // Packet fields one slot ahead of the line
  usb_tx_sequencer u_seq (
    .i_clk_12MHz (i_clk_12MHz),
    .i_rst_n     (i_rst_n),
    .i_start     (start),
    .i_ctrl      (ctrl),
    .i_stall     (stall),
    .i_rd_byte   (rd_byte),
    .o_rd_idx    (rd_idx),
    .o_bit       (tx_bit)
  );

  // Follows the same slots as the line encoder
  usb_tx_crc16 u_crc (
    .i_clk_12MHz (i_clk_12MHz),
    .i_rst_n     (i_rst_n),
    .i_bit       (tx_bit),
    .i_stall     (stall),
    .o_crc_bit   (crc_bit)
  );

  usb_tx_line u_line (
    .i_clk_12MHz (i_clk_12MHz),
    .i_rst_n     (i_rst_n),
    .i_bit       (tx_bit),
    .i_crc_bit   (crc_bit),
    .o_stall     (stall),
    .o_done      (done),
    .o_dp        (o_dp),
    .o_dn        (o_dn),
    .o_tx_en     (o_tx_en)
  );

endmodule

/* usb_tx_properties.sv */
`timescale 1ns/1ps

module usb_tx_properties (
  input logic i_clk_12MHz,
  input logic i_rst_n,
  input logic i_stall,
  input logic i_dp,
  input logic i_dn,
  input logic i_tx_en
);

  logic se0;
  logic is_j;

  assign se0  = {i_dp, i_dn} == usb_tx_pkg::line_se0;
  assign is_j = {i_dp, i_dn} == usb_tx_pkg::line_j;

  // EOP needs a second SE0 bit time
  se0_second: assert property (@(posedge i_clk_12MHz) disable iff (!i_rst_n)
    $rose(se0) |=> se0)
    else $error("SE0 lasted only one bit time");

  // Two SE0 bit times, then J
  se0_then_j: assert property (@(posedge i_clk_12MHz) disable iff (!i_rst_n)
    (se0 && $past(se0)) |=> is_j)
    else $error("EOP not closed by J after two SE0 bit times");

  // A stuffed zero is never followed by another one
  stall_single: assert property (@(posedge i_clk_12MHz) disable iff (!i_rst_n)
    i_stall |=> !i_stall)
    else $error("stall high on two cycles in a row");

  // Idle line
  idle_is_j: assert property (@(posedge i_clk_12MHz) disable iff (!i_rst_n)
    !i_tx_en |-> is_j)
    else $error("line not J while output enable is low");

endmodule

bind usb_tx_line usb_tx_properties u_props (
  .i_clk_12MHz (i_clk_12MHz),
  .i_rst_n     (i_rst_n),
  .i_stall     (o_stall),
  .i_dp        (o_dp),
  .i_dn        (o_dn),
  .i_tx_en     (o_tx_en)
);

/* tb_usb_tx.sv */
`timescale 1ns/1ps

module tb_usb_tx;

  logic       clk_12MHz;
  logic       rst_n;
  logic       wb_cyc;
  logic       wb_stb;
  logic       wb_we;
  logic [3:0] wb_adr;
  logic [7:0] wb_dat_w;
  logic [7:0] wb_dat_r;
  logic       wb_ack;
  logic       dp;
  logic       dn;
  logic       tx_en;

  // Stimulus records of 11 bytes each
  logic [7:0] stim_mem [0:255];
  // Payload of the packet being loaded, also kept for queued packets
  logic [7:0] payload [0:7];
  logic [7:0] exp_q [$];
  int         exp_len_q [$];
  logic [7:0] got_q [$];
  integer     seed;
  int         wait_limit;
  int         pkts_sent;
  int         pkts_done;
  int         ack_done_seen;
  logic       ack_tx_en_seen;

  // Line decoder state
  logic [1:0] prev_lvl;
  logic [7:0] cur_byte;
  int         bit_idx;
  int         ones_run;
  int         se0_run;
  logic       pkt_over;
  logic       pkt_end;

  usb_tx_top DUT (
    .i_clk_12MHz (clk_12MHz),
    .i_rst_n     (rst_n),
    .i_wb_cyc    (wb_cyc),
    .i_wb_stb    (wb_stb),
    .i_wb_we     (wb_we),
    .i_wb_adr    (wb_adr),
    .i_wb_dat    (wb_dat_w),
    .o_wb_dat    (wb_dat_r),
    .o_wb_ack    (wb_ack),
    .o_dp        (dp),
    .o_dn        (dn),
    .o_tx_en     (tx_en)
  );

  // 4 ns period
  always #2 clk_12MHz = ~clk_12MHz;

  task automatic end_with_failure();
    $display("Errors found");
    $fatal(1);
  endtask

  task automatic fail_plain(input string why);
    $display("ERROR: %s", why);
    end_with_failure();
  endtask

  task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] got);
    if (got !== exp) begin
      $display("[FAIL] %s: expected 0x%0h, got 0x%0h", name, exp, got);
      end_with_failure();
    end
  endtask

  // USB CRC16, reflected poly 0xA001, seed all ones, result inverted
  function automatic logic [15:0] crc16_ref(input int n);
    logic [15:0] crc;
    crc = 16'hffff;
    for (int i = 0; i < n; i++) begin
      crc = crc ^ {8'h00, payload[i]};
      for (int k = 0; k < 8; k++) begin
        if (crc[0]) begin
          crc = (crc >> 1) ^ 16'ha001;
        end else begin
          crc = crc >> 1;
        end
      end
    end
    return ~crc;
  endfunction

  // Byte list the line should carry for one packet
  task automatic build_expected(input logic [3:0] pid, input logic [3:0] nb);
    logic [15:0] crc;
    logic        is_data;
    is_data = pid[1:0] == usb_tx_pkg::pid_grp_data;
    // SYNC decodes as seven zeros then a one
    exp_q.push_back(8'h80);
    exp_q.push_back({~pid, pid});
    if (is_data) begin
      for (int i = 0; i < nb; i++) begin
        exp_q.push_back(payload[i]);
      end
      crc = crc16_ref(nb);
      // CRC low byte goes out first
      exp_q.push_back(crc[7:0]);
      exp_q.push_back(crc[15:8]);
      exp_len_q.push_back(int'(nb) + 4);
    end else begin
      exp_len_q.push_back(2);
    end
  endtask

  // One Wishbone classic transfer, driven on the falling edge
  task automatic bus_access(input logic we, input logic [3:0] adr, input logic [7:0] wdat,
                            output logic [7:0] rdat);
    int waited;
    @(negedge clk_12MHz);
    wb_cyc   = 1'b1;
    wb_stb   = 1'b1;
    wb_we    = we;
    wb_adr   = adr;
    wb_dat_w = wdat;
    waited   = 0;
    @(negedge clk_12MHz);
    while (!wb_ack) begin
      waited++;
      if (waited > wait_limit) begin
        fail_plain("timeout waiting for the Wishbone ack");
      end
      @(negedge clk_12MHz);
    end
    rdat           = wb_dat_r;
    // Snapshot for the back-pressure check
    ack_done_seen  = pkts_done;
    ack_tx_en_seen = tx_en;
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we  = 1'b0;
    @(negedge clk_12MHz);
    check_value("o_wb_ack width", 0, wb_ack);
  endtask

  // Write the payload into the buffer, then read all of it back
  task automatic load_payload(input logic [3:0] nb);
    logic [7:0] rd;
    for (int i = 0; i < nb; i++) begin
      bus_access(1'b1, usb_tx_pkg::addr_buf_base + 4'(i), payload[i], rd);
    end
    for (int i = 0; i < nb; i++) begin
      bus_access(1'b0, usb_tx_pkg::addr_buf_base + 4'(i), 8'h00, rd);
      check_value($sformatf("o_wb_dat buffer %0d", i), payload[i], rd);
    end
  endtask

  // Wait until every requested packet left the line, then check idle
  task automatic wait_line_idle();
    logic [7:0] rd;
    int         waited;
    waited = 0;
    while (pkts_done != pkts_sent) begin
      @(negedge clk_12MHz);
      waited++;
      if (waited > wait_limit) begin
        fail_plain("timeout waiting for the packet to finish on the line");
      end
    end
    check_value("o_tx_en between packets", 0, tx_en);
    check_value("line state between packets", usb_tx_pkg::line_j, {dp, dn});
    bus_access(1'b0, usb_tx_pkg::addr_status, 8'h00, rd);
    check_value("status busy after packet", 0, rd[0]);
  endtask

  task automatic reset_decoder();
    prev_lvl = usb_tx_pkg::line_j;
    cur_byte = 8'h00;
    bit_idx  = 0;
    ones_run = 0;
    se0_run  = 0;
    pkt_over = 1'b0;
    got_q.delete();
  endtask

  task automatic compare_packet();
    int len;
    if (exp_len_q.size() == 0) begin
      fail_plain("a packet appeared on the line that was never requested");
    end
    len = exp_len_q.pop_front();
    check_value("bits left in partial byte", 0, bit_idx);
    check_value("packet byte count", len, got_q.size());
    for (int i = 0; i < len; i++) begin
      check_value($sformatf("line byte %0d", i), exp_q.pop_front(), got_q[i]);
    end
    got_q.delete();
  endtask

  // NRZI decode and unstuffing of one line sample
  task automatic sample_line(input logic [1:0] lvl);
    logic b;
    pkt_end = 1'b0;
    if (lvl == usb_tx_pkg::line_se0) begin
      se0_run++;
      if (se0_run > 2) begin
        fail_plain("more than two SE0 bit times at the end of a packet");
      end
    end else if (se0_run != 0) begin
      check_value("SE0 bit times", 2, se0_run);
      check_value("line after SE0", usb_tx_pkg::line_j, lvl);
      compare_packet();
      pkt_over = 1'b1;
      pkt_end  = 1'b1;
    end else begin
      // Same level means a one
      b        = lvl == prev_lvl;
      prev_lvl = lvl;
      if (ones_run == 6) begin
        if (b) begin
          fail_plain("seven ones in a row on the line without a stuffed zero");
        end
        // Stuffed zero, not part of the data
        ones_run = 0;
      end else begin
        ones_run = b ? ones_run + 1 : 0;
        cur_byte[bit_idx] = b;
        bit_idx++;
        if (bit_idx == 8) begin
          got_q.push_back(cur_byte);
          bit_idx = 0;
        end
      end
    end
  endtask

  // Line monitor, samples in the middle of each bit time
  always @(negedge clk_12MHz) begin
    if (!rst_n) begin
      reset_decoder();
      pkts_done <= 0;
    end else if (!tx_en) begin
      if ({dp, dn} != usb_tx_pkg::line_j) begin
        fail_plain("line is not J while o_tx_en is low");
      end
      reset_decoder();
    end else if (pkt_over) begin
      fail_plain("o_tx_en still high after the closing J");
    end else begin
      sample_line({dp, dn});
      if (pkt_end) begin
        pkts_done <= pkts_done + 1;
      end
    end
  end

  initial begin
    logic [7:0] rd;
    logic [7:0] mode;
    logic [3:0] pid;
    logic [3:0] nb;
    int         base;
    clk_12MHz  = 1'b0;
    rst_n      = 1'b0;
    wb_cyc     = 1'b0;
    wb_stb     = 1'b0;
    wb_we      = 1'b0;
    wb_adr     = 4'd0;
    wb_dat_w   = 8'h00;
    seed       = 17747;
    wait_limit = 600;
    pkts_sent  = 0;
    $readmemh("usb_tx_input.txt", stim_mem);
    repeat (8) @(negedge clk_12MHz);
    rst_n = 1'b1;
    @(negedge clk_12MHz);
    check_value("o_tx_en after reset", 0, tx_en);
    check_value("line state after reset", usb_tx_pkg::line_j, {dp, dn});
    base = 0;
    // Mode ff ends the list
    while (base < 240 && stim_mem[base] != 8'hff) begin
      mode = stim_mem[base];
      pid  = stim_mem[base + 1][3:0];
      nb   = stim_mem[base + 2][3:0];
      // Mode 02 goes out while the previous packet is still on the line
      if (mode != 8'h02) begin
        wait_line_idle();
        for (int i = 0; i < nb; i++) begin
          payload[i] = (mode == 8'h01) ? 8'($random(seed)) : stim_mem[base + 3 + i];
        end
        load_payload(nb);
      end
      build_expected(pid, nb);
      bus_access(1'b1, usb_tx_pkg::addr_ctrl, {nb, pid}, rd);
      // Held write must be acked only once the previous EOP is over
      check_value("packets finished at control ack", pkts_sent, ack_done_seen);
      check_value("o_tx_en at control ack", 0, ack_tx_en_seen);
      pkts_sent++;
      bus_access(1'b0, usb_tx_pkg::addr_status, 8'h00, rd);
      check_value("status busy during packet", 1, rd[0]);
      base += 11;
    end
    wait_line_idle();
    $display("No errors");
    $finish;
  end

endmodule

/* usb_tx_input.txt */
// Columns in hex: mode pid nbytes b0 b1 b2 b3 b4 b5 b6 b7
// Mode 00 payload as listed, 01 random payload, 02 sent during the previous packet, buffer reused
00 03 00 00 00 00 00 00 00 00 00
00 0b 01 a5 00 00 00 00 00 00 00
00 03 02 01 80 00 00 00 00 00 00
00 0b 03 00 ff 7e 00 00 00 00 00
00 03 04 de ad be ef 00 00 00 00
00 0b 05 12 34 56 78 9a 00 00 00
00 03 06 3f 7f fe fc 00 01 00 00
00 0b 07 55 aa 55 aa 0f f0 c3 00
00 03 08 01 02 04 08 10 20 40 80
00 03 08 ff ff ff ff ff ff ff ff
00 02 00 00 00 00 00 00 00 00 00
02 0a 00 00 00 00 00 00 00 00 00
00 0e 00 00 00 00 00 00 00 00 00
01 0b 08 00 00 00 00 00 00 00 00
02 03 08 00 00 00 00 00 00 00 00
01 03 05 00 00 00 00 00 00 00 00
00 0b 04 ff ff ff ff 00 00 00 00
02 0b 04 00 00 00 00 00 00 00 00
ff

/* sim.f */
usb_tx_pkg.sv
usb_tx_regs.sv
usb_tx_sequencer.sv
usb_tx_crc16.sv
usb_tx_line.sv
usb_tx_top.sv
usb_tx_properties.sv
tb_usb_tx.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the USB transmit testbench with Verilator

cd "$(dirname "$0")" || exit 1

log=sim.log

if ! verilator --binary --timing --assert -Wno-fatal -f sim.f \
    --top-module tb_usb_tx -Mdir obj_dir -o tb_usb_tx_sim; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/tb_usb_tx_sim > "$log" 2>&1
status=$?
cat "$log"

# The fail message in the log decides the result
if grep -q "Errors found" "$log"; then
  echo "Simulation FAILED"
  exit 1
fi
if [ "$status" -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi
if ! grep -q "No errors" "$log"; then
  echo "Simulation ended without a result line"
  exit 1
fi
echo "Simulation passed"
exit 0
